/* include/timer_consts.svh */
// Widths, register offsets and reset values of the APB machine timer.
// Included by the package and by every module that sizes or decodes with them.

`ifndef TIMER_CONSTS_SVH
`define TIMER_CONSTS_SVH

// APB bus widths
`define TIMER_ADDR_W 5
`define TIMER_DATA_W 32

// Byte offsets of the timer registers
`define TIMER_OFS_MTIME_LO 5'h00
`define TIMER_OFS_MTIME_HI 5'h04
`define TIMER_OFS_CMP_LO   5'h08
`define TIMER_OFS_CMP_HI   5'h0C
`define TIMER_OFS_CTRL     5'h10
`define TIMER_OFS_STATUS   5'h14

// Prescaler width and compare value after reset
`define TIMER_PRESC_W   8
`define TIMER_CMP_RESET 64'hFFFF_FFFF_FFFF_FFFF

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the machine timer testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f timer_top.f --top-module timer_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build stopped with status $status"
    exit "$status"
fi

./obj_dir/Vtimer_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation stopped with status $status"
    exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

/* source/apb_timer_port.sv */
// APB slave front end of the timer. Decodes PADDR, flags illegal accesses
// with PSLVERR and hands one write or read select per transfer to the registers.

`default_nettype none

`include "timer_consts.svh"

module apb_timer_port (
    input  logic                      clk,
    input  logic                      reset_n,
    input  timer_pkg::apb_req_t       apb_i,
    input  logic [`TIMER_DATA_W-1:0]  rd_data_i,
    output timer_pkg::apb_rsp_t       apb_o,
    output timer_pkg::reg_wr_t        wr_o,
    output timer_pkg::reg_sel_t       rd_sel_o
);
    timer_pkg::reg_sel_t sel;
    logic                mapped;
    logic                err;
    logic                access_phase;
    logic                setup_q;

    // Address decode, only word-aligned offsets of real registers map
    always_comb begin
        sel    = timer_pkg::sel_mtime_lo;
        mapped = 1'b1;
        case (apb_i.paddr)
            `TIMER_OFS_MTIME_LO: sel = timer_pkg::sel_mtime_lo;
            `TIMER_OFS_MTIME_HI: sel = timer_pkg::sel_mtime_hi;
            `TIMER_OFS_CMP_LO:   sel = timer_pkg::sel_cmp_lo;
            `TIMER_OFS_CMP_HI:   sel = timer_pkg::sel_cmp_hi;
            `TIMER_OFS_CTRL:     sel = timer_pkg::sel_ctrl;
            `TIMER_OFS_STATUS:   sel = timer_pkg::sel_status;
            default:             mapped = 1'b0;
        endcase
    end

    // Status is read only
    assign err = !mapped || (apb_i.pwrite && sel == timer_pkg::sel_status);

    assign access_phase = apb_i.psel && apb_i.penable;

    // Remembers that the last cycle was a setup phase
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= apb_i.psel && !apb_i.penable;
        end
    end

    // Zero wait states, every access phase completes
    assign apb_o.pready  = access_phase;
    assign apb_o.pslverr = access_phase && err;
    assign apb_o.prdata  = (access_phase && !apb_i.pwrite) ? rd_data_i : '0;

    // A write only reaches the registers when it is legal
    assign wr_o.valid = access_phase && setup_q && apb_i.pwrite && !err;
    assign wr_o.sel   = sel;
    assign wr_o.strb  = apb_i.pstrb;
    assign wr_o.data  = apb_i.pwdata;

    assign rd_sel_o = sel;

    // Every access phase must follow a setup cycle
    a_setup_before_access : assert property (
        @(posedge clk) disable iff (!reset_n)
        (apb_i.psel && apb_i.penable) |-> setup_q
    );

endmodule

`default_nettype wire

/* source/mtime_counter.sv */
// Free-running 64-bit mtime with prescaler and byte-strobed load.
// Compares against mtimecmp and registers the machine timer interrupt.

`default_nettype none

`include "timer_consts.svh"

module mtime_counter (
    input  logic                      clk,
    input  logic                      reset_n,
    input  timer_pkg::timer_cfg_t     cfg_i,
    input  timer_pkg::mtime_load_t    load_i,
    output timer_pkg::timer_word_u    mtime_o,
    output logic                      pending_o,
    output logic                      mti_o
);
    logic [`TIMER_PRESC_W-1:0]  presc_cnt;
    logic                       tick;
    timer_pkg::timer_word_u     mtime_q;
    timer_pkg::timer_word_u     load_word;
    logic                       at_cmp;
    logic                       mti_q;

    // One tick every prescale+1 enabled cycles
    assign tick = cfg_i.enable && (presc_cnt >= cfg_i.prescale);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            presc_cnt <= '0;
        end else if (load_i.valid || tick) begin
            presc_cnt <= '0;
        end else if (cfg_i.enable) begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    // Current count with the strobed bytes of one half replaced
    always_comb begin
        load_word = mtime_q;
        if (load_i.hi) begin
            load_word.word.hi = timer_pkg::merge_bytes(mtime_q.word.hi, load_i.data,
                                                       load_i.strb);
        end else begin
            load_word.word.lo = timer_pkg::merge_bytes(mtime_q.word.lo, load_i.data,
                                                       load_i.strb);
        end
    end

    // A load wins over the increment in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mtime_q.count <= '0;
        end else if (load_i.valid) begin
            mtime_q <= load_word;
        end else if (tick) begin
            mtime_q.count <= mtime_q.count + 1'b1;
        end
    end

    assign at_cmp = mtime_q.count >= cfg_i.mtimecmp;

    // Interrupt follows the compare one cycle later
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mti_q <= 1'b0;
        end else begin
            mti_q <= at_cmp;
        end
    end

    assign mtime_o   = mtime_q;
    assign mti_o     = mti_q;
    assign pending_o = mti_q;

    // Disabled and not loaded means the count holds
    a_hold_when_disabled : assert property (
        @(posedge clk) disable iff (!reset_n)
        (!cfg_i.enable && !load_i.valid) |=> $stable(mtime_q.count)
    );

endmodule

`default_nettype wire

/* source/timer_pkg.sv */
// Shared types of the machine timer: APB structs, register select, internal
// write and load requests, and the 64-bit timer word.

`default_nettype none

`include "timer_consts.svh"

package timer_pkg;

    typedef struct packed {
        logic                         psel;
        logic                         penable;
        logic                         pwrite;
        logic [`TIMER_ADDR_W-1:0]     paddr;
        logic [`TIMER_DATA_W-1:0]     pwdata;
        logic [`TIMER_DATA_W/8-1:0]   pstrb;
    } apb_req_t;

    typedef struct packed {
        logic                         pready;
        logic [`TIMER_DATA_W-1:0]     prdata;
        logic                         pslverr;
    } apb_rsp_t;

    typedef enum logic [2:0] {
        sel_mtime_lo,
        sel_mtime_hi,
        sel_cmp_lo,
        sel_cmp_hi,
        sel_ctrl,
        sel_status
    } reg_sel_t;

    // One register write, applied at the next clock edge
    typedef struct packed {
        logic                         valid;
        reg_sel_t                     sel;
        logic [`TIMER_DATA_W/8-1:0]   strb;
        logic [`TIMER_DATA_W-1:0]     data;
    } reg_wr_t;

    typedef struct packed {
        logic                         enable;
        logic [`TIMER_PRESC_W-1:0]    prescale;
        logic [2*`TIMER_DATA_W-1:0]   mtimecmp;
    } timer_cfg_t;

    // Load request to the counter; hi selects the upper half
    typedef struct packed {
        logic                         valid;
        logic                         hi;
        logic [`TIMER_DATA_W/8-1:0]   strb;
        logic [`TIMER_DATA_W-1:0]     data;
    } mtime_load_t;

    typedef struct packed {
        logic [`TIMER_DATA_W-1:0]     hi;
        logic [`TIMER_DATA_W-1:0]     lo;
    } timer_halves_t;

    // Same 64 bits seen as a count or as two bus words
    typedef union packed {
        logic [2*`TIMER_DATA_W-1:0]   count;
        timer_halves_t                word;
    } timer_word_u;

    // Replaces the strobed bytes of old_word with those of new_word
    function automatic logic [`TIMER_DATA_W-1:0] merge_bytes(
        input logic [`TIMER_DATA_W-1:0]   old_word,
        input logic [`TIMER_DATA_W-1:0]   new_word,
        input logic [`TIMER_DATA_W/8-1:0] strb
    );
        logic [`TIMER_DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < `TIMER_DATA_W/8; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

/* source/timer_regs.sv */
// Configuration registers of the timer: mtimecmp, enable and prescale.
// Forwards mtime writes to the counter and builds the APB read data.

`default_nettype none

`include "timer_consts.svh"

module timer_regs (
    input  logic                      clk,
    input  logic                      reset_n,
    input  timer_pkg::reg_wr_t        wr_i,
    input  timer_pkg::reg_sel_t       rd_sel_i,
    input  timer_pkg::timer_word_u    mtime_i,
    input  logic                      pending_i,
    output logic [`TIMER_DATA_W-1:0]  rd_data_o,
    output timer_pkg::timer_cfg_t     cfg_o,
    output timer_pkg::mtime_load_t    load_o
);
    timer_pkg::timer_word_u         cmp_q;
    logic                           enable_q;
    logic [`TIMER_PRESC_W-1:0]      presc_q;
    logic [`TIMER_DATA_W-1:0]       ctrl_rd;
    logic [`TIMER_DATA_W-1:0]       status_rd;
    logic                           wr_mtime;
    logic                           wr_ctrl;

    assign wr_mtime = wr_i.valid && (wr_i.sel == timer_pkg::sel_mtime_lo ||
                                     wr_i.sel == timer_pkg::sel_mtime_hi);
    assign wr_ctrl  = wr_i.valid && wr_i.sel == timer_pkg::sel_ctrl;

    // Compare value, byte merged into the selected half
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cmp_q.count <= `TIMER_CMP_RESET;
        end else if (wr_i.valid) begin
            case (wr_i.sel)
                timer_pkg::sel_cmp_lo: begin
                    cmp_q.word.lo <= timer_pkg::merge_bytes(cmp_q.word.lo, wr_i.data,
                                                            wr_i.strb);
                end
                timer_pkg::sel_cmp_hi: begin
                    cmp_q.word.hi <= timer_pkg::merge_bytes(cmp_q.word.hi, wr_i.data,
                                                            wr_i.strb);
                end
                default: begin
                    cmp_q <= cmp_q;
                end
            endcase
        end
    end

    // Ctrl layout: enable in bit 0, prescale in byte 1
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_q <= 1'b1;
            presc_q  <= '0;
        end else if (wr_ctrl) begin
            if (wr_i.strb[0]) begin
                enable_q <= wr_i.data[0];
            end
            if (wr_i.strb[1]) begin
                presc_q <= wr_i.data[8 +: `TIMER_PRESC_W];
            end
        end
    end

    assign cfg_o.enable   = enable_q;
    assign cfg_o.prescale = presc_q;
    assign cfg_o.mtimecmp = cmp_q.count;

    // mtime writes go straight to the counter.
    // A ctrl write sends an empty load so the prescaler restarts.
    assign load_o.valid = wr_mtime || wr_ctrl;
    assign load_o.hi    = wr_i.sel == timer_pkg::sel_mtime_hi;
    assign load_o.strb  = wr_mtime ? wr_i.strb : '0;
    assign load_o.data  = wr_i.data;

    always_comb begin
        ctrl_rd                        = '0;
        ctrl_rd[0]                     = enable_q;
        ctrl_rd[8 +: `TIMER_PRESC_W]   = presc_q;
    end

    assign status_rd = {{(`TIMER_DATA_W-1){1'b0}}, pending_i};

    // Read mux
    always_comb begin
        case (rd_sel_i)
            timer_pkg::sel_mtime_lo: rd_data_o = mtime_i.word.lo;
            timer_pkg::sel_mtime_hi: rd_data_o = mtime_i.word.hi;
            timer_pkg::sel_cmp_lo:   rd_data_o = cmp_q.word.lo;
            timer_pkg::sel_cmp_hi:   rd_data_o = cmp_q.word.hi;
            timer_pkg::sel_ctrl:     rd_data_o = ctrl_rd;
            timer_pkg::sel_status:   rd_data_o = status_rd;
            default:                 rd_data_o = '0;
        endcase
    end

    // Configuration only moves on a write from the bus
    a_cfg_stable : assert property (
        @(posedge clk) disable iff (!reset_n)
        !wr_i.valid |=> $stable(cfg_o)
    );

endmodule

`default_nettype wire

/* source/timer_top.sv */
// Top level of the APB machine timer. Connects the bus port, the
// configuration registers and the mtime counter.

`default_nettype none

`include "timer_consts.svh"

module timer_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  timer_pkg::apb_req_t         apb_i,
    output timer_pkg::apb_rsp_t         apb_o,
    output logic                        mti_o,
    output logic [2*`TIMER_DATA_W-1:0]  mtime_o
);
    timer_pkg::reg_wr_t         wr;
    timer_pkg::reg_sel_t        rd_sel;
    logic [`TIMER_DATA_W-1:0]   rd_data;
    timer_pkg::timer_cfg_t      cfg;
    timer_pkg::mtime_load_t     load;
    timer_pkg::timer_word_u     mtime;
    logic                       pending;

    apb_timer_port u_port (
        .clk       (clk),
        .reset_n   (reset_n),
        .apb_i     (apb_i),
        .rd_data_i (rd_data),
        .apb_o     (apb_o),
        .wr_o      (wr),
        .rd_sel_o  (rd_sel)
    );

    timer_regs u_regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .wr_i      (wr),
        .rd_sel_i  (rd_sel),
        .mtime_i   (mtime),
        .pending_i (pending),
        .rd_data_o (rd_data),
        .cfg_o     (cfg),
        .load_o    (load)
    );

    mtime_counter u_counter (
        .clk       (clk),
        .reset_n   (reset_n),
        .cfg_i     (cfg),
        .load_i    (load),
        .mtime_o   (mtime),
        .pending_o (pending),
        .mti_o     (mti_o)
    );

    assign mtime_o = mtime.count;

endmodule

`default_nettype wire

/* timer_top.f */
+incdir+include
source/timer_pkg.sv
source/apb_timer_port.sv
source/timer_regs.sv
source/mtime_counter.sv
source/timer_top.sv
verif/timer_tb_clk.sv
verif/timer_tb.sv

/* verif/timer_tb.sv */
// Table-driven testbench of the APB machine timer. Each table step is an APB
// transfer, an idle gap or an interrupt wait, checked against a reference model.

`default_nettype none

`include "timer_consts.svh"

module timer_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int OP_WR        = 0;
    localparam int OP_RD        = 1;
    localparam int OP_IDLE      = 2;
    localparam int OP_MTI       = 3;
    localparam int OP_AHEAD     = 4;
    localparam int XFER_TIMEOUT = 16;

    logic                           clk;
    logic                           reset_n;
    timer_pkg::apb_req_t            apb_req;
    timer_pkg::apb_rsp_t            apb_rsp;
    logic                           mti;
    logic [2*`TIMER_DATA_W-1:0]     mtime;
    int                             cycle_cnt = 0;
    integer                         seed;

    // Stimulus table with one entry per step
    string                          step_name[$];
    int                             step_op[$];
    logic [`TIMER_ADDR_W-1:0]       step_ofs[$];
    logic [3:0]                     step_strb[$];
    logic [31:0]                    step_data[$];
    logic                           step_err[$];
    int                             step_tol[$];

    // Reference model of mtime as m_base at cycle m_base_cyc plus the ticks since
    logic [63:0]                    m_base;
    int                             m_base_cyc;
    logic                           m_enable;
    logic [7:0]                     m_presc;
    logic [63:0]                    m_cmp;

    timer_tb_clk u_clk (
        .clk_o (clk)
    );

    timer_top dut (
        .clk     (clk),
        .reset_n (reset_n),
        .apb_i   (apb_req),
        .apb_o   (apb_rsp),
        .mti_o   (mti),
        .mtime_o (mtime)
    );

    // Counts rising edges so that reads can be placed in time
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic void add_step(input string name, input int op,
                                     input logic [`TIMER_ADDR_W-1:0] ofs, input logic [3:0] strb,
                                     input logic [31:0] data, input logic err, input int tol);
        step_name.push_back(name);
        step_op.push_back(op);
        step_ofs.push_back(ofs);
        step_strb.push_back(strb);
        step_data.push_back(data);
        step_err.push_back(err);
        step_tol.push_back(tol);
    endfunction

    function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [63:0] model_mtime(input int cyc);
        int ticks;
        if (!m_enable) begin
            return m_base;
        end
        ticks = (cyc - m_base_cyc) / (int'(m_presc) + 1);
        return m_base + 64'(ticks);
    endfunction

    // A legal write sampled at cycle cyc lands on the following edge
    task automatic model_write(input logic [`TIMER_ADDR_W-1:0] ofs, input logic [3:0] strb,
                               input logic [31:0] data, input int cyc);
        logic [63:0] cur;
        cur = model_mtime(cyc);
        case (ofs)
            `TIMER_OFS_MTIME_LO: begin
                m_base     = {cur[63:32], byte_merge(cur[31:0], data, strb)};
                m_base_cyc = cyc + 1;
            end
            `TIMER_OFS_MTIME_HI: begin
                m_base     = {byte_merge(cur[63:32], data, strb), cur[31:0]};
                m_base_cyc = cyc + 1;
            end
            `TIMER_OFS_CMP_LO: m_cmp[31:0] = byte_merge(m_cmp[31:0], data, strb);
            `TIMER_OFS_CMP_HI: m_cmp[63:32] = byte_merge(m_cmp[63:32], data, strb);
            `TIMER_OFS_CTRL: begin
                // Prescaler restarts from the value held at the write
                m_base     = cur;
                m_base_cyc = cyc + 1;
                if (strb[0]) begin
                    m_enable = data[0];
                end
                if (strb[1]) begin
                    m_presc = data[15:8];
                end
            end
            default: begin
            end
        endcase
    endtask

    function automatic logic [31:0] model_read(input logic [`TIMER_ADDR_W-1:0] ofs,
                                               input int cyc);
        logic [63:0] cur;
        logic [63:0] prev;
        cur  = model_mtime(cyc);
        prev = model_mtime(cyc - 1);
        case (ofs)
            `TIMER_OFS_MTIME_LO: return cur[31:0];
            `TIMER_OFS_MTIME_HI: return cur[63:32];
            `TIMER_OFS_CMP_LO:   return m_cmp[31:0];
            `TIMER_OFS_CMP_HI:   return m_cmp[63:32];
            `TIMER_OFS_CTRL:     return {16'd0, m_presc, 7'd0, m_enable};
            // Interrupt is registered, so status lags the compare by a cycle
            `TIMER_OFS_STATUS:   return {31'd0, prev >= m_cmp};
            default:             return 32'd0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual, input int tol);
        logic [63:0] diff;
        diff = (actual >= expected) ? actual - expected : expected - actual;
        if (diff > 64'(tol)) begin
            $display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // One APB transfer of setup then access that returns the cycle of the access sample
    task automatic apb_transfer(input logic wr, input logic [`TIMER_ADDR_W-1:0] ofs,
                                input logic [3:0] strb, input logic [31:0] data,
                                output logic [31:0] rdata, output logic err, output int cyc);
        int waited;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = ofs;
        apb_req.pwdata  = wr ? data : 32'd0;
        apb_req.pstrb   = wr ? strb : 4'd0;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        waited = 0;
        while (!apb_rsp.pready) begin
            if (waited >= XFER_TIMEOUT) begin
                $display("Timeout: no PREADY within %0d cycles at offset 0x%0h",
                         XFER_TIMEOUT, ofs);
                $display("Regression failed");
                $fatal(1, "APB transfer timed out");
            end
            @(negedge clk);
            #1;
            waited++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        cyc   = cycle_cnt;
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic wait_mti(input string name, input logic level, input int max_cycles);
        int waited;
        waited = 0;
        while (mti !== level) begin
            if (waited >= max_cycles) begin
                $display("Timeout: %s, mti_o did not reach %0d within %0d cycles",
                         name, level, max_cycles);
                $display("Regression failed");
                $fatal(1, "interrupt wait timed out");
            end
            @(negedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic build_table();
        add_step("mtime_lo after reset", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("mtime_lo second read", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("mtime_hi after reset", OP_RD, `TIMER_OFS_MTIME_HI, 4'h0, 32'd0, 1'b0, 0);
        add_step("cmp_lo after reset", OP_RD, `TIMER_OFS_CMP_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("cmp_hi after reset", OP_RD, `TIMER_OFS_CMP_HI, 4'h0, 32'd0, 1'b0, 0);
        add_step("ctrl after reset", OP_RD, `TIMER_OFS_CTRL, 4'h0, 32'd0, 1'b0, 0);
        add_step("mti after reset", OP_MTI, 5'h00, 4'h0, 32'd0, 1'b0, 0);
        // Byte strobes on the compare halves
        add_step("cmp_lo strobe 0101", OP_WR, `TIMER_OFS_CMP_LO, 4'b0101, $random(seed), 1'b0, 0);
        add_step("cmp_lo merged", OP_RD, `TIMER_OFS_CMP_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("cmp_lo strobe 1110", OP_WR, `TIMER_OFS_CMP_LO, 4'b1110, $random(seed), 1'b0, 0);
        add_step("cmp_lo merged again", OP_RD, `TIMER_OFS_CMP_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("cmp_hi strobe 1010", OP_WR, `TIMER_OFS_CMP_HI, 4'b1010, $random(seed), 1'b0, 0);
        add_step("cmp_hi merged", OP_RD, `TIMER_OFS_CMP_HI, 4'h0, 32'd0, 1'b0, 0);
        // mtime loads and a carry into the upper half
        add_step("mtime_hi load", OP_WR, `TIMER_OFS_MTIME_HI, 4'hF, 32'h0000_0012, 1'b0, 0);
        add_step("mtime_lo near carry", OP_WR, `TIMER_OFS_MTIME_LO, 4'hF, 32'hFFFF_FFF0, 1'b0, 0);
        add_step("mtime_hi before carry", OP_RD, `TIMER_OFS_MTIME_HI, 4'h0, 32'd0, 1'b0, 0);
        add_step("idle for carry", OP_IDLE, 5'h00, 4'h0, 32'd20, 1'b0, 0);
        add_step("mtime_hi after carry", OP_RD, `TIMER_OFS_MTIME_HI, 4'h0, 32'd0, 1'b0, 0);
        add_step("mtime_lo after carry", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("mtime_lo byte 1", OP_WR, `TIMER_OFS_MTIME_LO, 4'b0010, 32'h0000_4000, 1'b0, 0);
        add_step("mtime_lo after byte load", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
        // Counter disabled, then prescaled
        add_step("ctrl disable", OP_WR, `TIMER_OFS_CTRL, 4'b0001, 32'd0, 1'b0, 0);
        add_step("mtime_lo held 1", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("mtime_lo held 2", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("mtime_lo held 3", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("ctrl disabled", OP_RD, `TIMER_OFS_CTRL, 4'h0, 32'd0, 1'b0, 0);
        add_step("ctrl prescale 3", OP_WR, `TIMER_OFS_CTRL, 4'b0011, 32'h0000_0301, 1'b0, 0);
        add_step("ctrl prescaled", OP_RD, `TIMER_OFS_CTRL, 4'h0, 32'd0, 1'b0, 0);
        add_step("idle prescaled", OP_IDLE, 5'h00, 4'h0, 32'd40, 1'b0, 0);
        add_step("mtime_lo prescaled 1", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 1);
        add_step("idle prescaled again", OP_IDLE, 5'h00, 4'h0, 32'd13, 1'b0, 0);
        add_step("mtime_lo prescaled 2", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 1);
        add_step("ctrl prescale 0", OP_WR, `TIMER_OFS_CTRL, 4'b0010, 32'd0, 1'b0, 0);
        add_step("mtime_lo full rate", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
        // Interrupt rise and clear
        add_step("cmp ahead of mtime", OP_AHEAD, 5'h00, 4'h0, 32'd30, 1'b0, 0);
        add_step("mti before match", OP_MTI, 5'h00, 4'h0, 32'd0, 1'b0, 0);
        add_step("mti rises", OP_MTI, 5'h00, 4'h0, 32'd1, 1'b0, 100);
        add_step("status pending", OP_RD, `TIMER_OFS_STATUS, 4'h0, 32'd0, 1'b0, 0);
        add_step("cmp_hi raised", OP_WR, `TIMER_OFS_CMP_HI, 4'hF, 32'hFFFF_FFFF, 1'b0, 0);
        add_step("mti falls", OP_MTI, 5'h00, 4'h0, 32'd0, 1'b0, 2);
        add_step("status clear", OP_RD, `TIMER_OFS_STATUS, 4'h0, 32'd0, 1'b0, 0);
        // Bus errors leave every register alone
        add_step("write unmapped 0x18", OP_WR, 5'h18, 4'hF, $random(seed), 1'b1, 0);
        add_step("read unmapped 0x1c", OP_RD, 5'h1C, 4'h0, 32'd0, 1'b1, 0);
        add_step("write status", OP_WR, `TIMER_OFS_STATUS, 4'hF, 32'd1, 1'b1, 0);
        add_step("write misaligned 0x06", OP_WR, 5'h06, 4'hF, $random(seed), 1'b1, 0);
        add_step("cmp_lo after errors", OP_RD, `TIMER_OFS_CMP_LO, 4'h0, 32'd0, 1'b0, 0);
        add_step("cmp_hi after errors", OP_RD, `TIMER_OFS_CMP_HI, 4'h0, 32'd0, 1'b0, 0);
        add_step("ctrl after errors", OP_RD, `TIMER_OFS_CTRL, 4'h0, 32'd0, 1'b0, 0);
        add_step("mtime_lo after errors", OP_RD, `TIMER_OFS_MTIME_LO, 4'h0, 32'd0, 1'b0, 0);
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          cyc;
        logic [63:0] target;
        seed       = 56;
        apb_req    = '0;
        reset_n    = 1'b0;
        m_base     = 64'd0;
        m_base_cyc = 0;
        m_enable   = 1'b1;
        m_presc    = 8'd0;
        m_cmp      = `TIMER_CMP_RESET;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n    = 1'b1;
        m_base_cyc = cycle_cnt;

        for (int i = 0; i < step_op.size(); i++) begin
            case (step_op[i])
                OP_WR: begin
                    apb_transfer(1'b1, step_ofs[i], step_strb[i], step_data[i], rdata, err, cyc);
                    check_value({step_name[i], " pslverr"}, 64'(step_err[i]), 64'(err), 0);
                    if (!step_err[i]) begin
                        model_write(step_ofs[i], step_strb[i], step_data[i], cyc);
                    end
                end
                OP_RD: begin
                    apb_transfer(1'b0, step_ofs[i], 4'h0, 32'd0, rdata, err, cyc);
                    check_value({step_name[i], " pslverr"}, 64'(step_err[i]), 64'(err), 0);
                    if (!step_err[i]) begin
                        check_value(step_name[i], 64'(model_read(step_ofs[i], cyc)),
                                    64'(rdata), step_tol[i]);
                    end
                    // Full 64-bit count port at the current edge
                    check_value({step_name[i], " mtime_o"}, model_mtime(cycle_cnt), mtime,
                                step_tol[i]);
                end
                OP_IDLE: begin
                    repeat (step_data[i]) @(negedge clk);
                end
                OP_MTI: begin
                    wait_mti(step_name[i], step_data[i][0], step_tol[i]);
                end
                OP_AHEAD: begin
                    // Low half first so the compare never drops below mtime on the way
                    target = model_mtime(cycle_cnt) + 64'(step_data[i]);
                    apb_transfer(1'b1, `TIMER_OFS_CMP_LO, 4'hF, target[31:0], rdata, err, cyc);
                    check_value({step_name[i], " lo pslverr"}, 64'd0, 64'(err), 0);
                    model_write(`TIMER_OFS_CMP_LO, 4'hF, target[31:0], cyc);
                    apb_transfer(1'b1, `TIMER_OFS_CMP_HI, 4'hF, target[63:32], rdata, err, cyc);
                    check_value({step_name[i], " hi pslverr"}, 64'd0, 64'(err), 0);
                    model_write(`TIMER_OFS_CMP_HI, 4'hF, target[63:32], cyc);
                end
                default: begin
                end
            endcase
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/timer_tb_clk.sv */
// Free-running testbench clock, 8 ns period, starting low.

`default_nettype none

module timer_tb_clk #(
    parameter int HALF_NS = 4
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_NS);
            clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire
